//--- common/cnn_pkg.sv
`default_nettype none

package cnn_pkg;

    //////////////////////////////////////////////////
    // number formats
    //////////////////////////////////////////////////

    // Q4.12 words for pixels, weights and coefficients
    localparam int DATA_WIDTH = 16;
    localparam int FRAC_SZ    = 12;
    localparam int PROD_WIDTH = 2 * DATA_WIDTH;
    // nine 32-bit products need 36 bits
    localparam int ACC_WIDTH  = 36;

    //////////////////////////////////////////////////
    // tile and kernel geometry
    //////////////////////////////////////////////////

    localparam int IMAGE_WIDTH    = 8;
    localparam int IMAGE_HEIGHT   = 8;
    localparam int COL_WIDTH      = $clog2(IMAGE_WIDTH);
    localparam int ROW_WIDTH      = $clog2(IMAGE_HEIGHT);
    localparam int KERNEL_SIZE    = 3;
    localparam int NUM_TAPS       = KERNEL_SIZE * KERNEL_SIZE;
    localparam int PAD_SZ         = KERNEL_SIZE / 2;
    localparam int POOL_SIZE      = 2;
    localparam int POOL_COLS      = IMAGE_WIDTH / POOL_SIZE;
    localparam int POOL_IDX_WIDTH = $clog2(POOL_COLS);

    // one spare row so the next input row never hits a row in use
    localparam int LB_ROWS    = KERNEL_SIZE + 1;
    localparam int SLOT_WIDTH = $clog2(LB_ROWS);

    typedef logic signed [DATA_WIDTH-1:0] pixel_t;
    typedef logic signed [PROD_WIDTH-1:0] prod_t;
    typedef logic signed [ACC_WIDTH-1:0]  acc_t;
    typedef logic [COL_WIDTH-1:0]         col_t;
    typedef logic [ROW_WIDTH-1:0]         row_t;

    // fixed-point limits
    localparam pixel_t PIXEL_MAX = {1'b0, {(DATA_WIDTH-1){1'b1}}};
    localparam pixel_t PIXEL_MIN = {1'b1, {(DATA_WIDTH-1){1'b0}}};
    localparam pixel_t Q_ONE     = pixel_t'(1 << FRAC_SZ);

    // taps row-major, taps[0] is the top-left tap
    typedef struct packed {
        pixel_t [NUM_TAPS-1:0] taps;
    } kernel_t;

    typedef struct packed {
        logic    valid;
        kernel_t taps;
    } conv_window_t;

    typedef struct packed {
        logic   valid;
        pixel_t data;
    } stage_t;

    typedef enum logic {
        IDLE,
        EMIT
    } win_state_t;

    // clamp a wide result into one Q4.12 word
    function automatic pixel_t sat_pixel(input acc_t value);
        if (value > acc_t'(PIXEL_MAX)) begin
            return PIXEL_MAX;
        end else if (value < acc_t'(PIXEL_MIN)) begin
            return PIXEL_MIN;
        end
        return pixel_t'(value);
    endfunction

endpackage

`default_nettype wire

//--- window_gen/window_gen.sv
`timescale 1ns/1ns
`default_nettype none

module window_gen import cnn_pkg::*; (
    input  wire          clk,
    input  wire          rst,
    input  wire pixel_t  pixel_in,
    input  wire          pixel_valid,
    output conv_window_t window
);

    pixel_t                line_mem [LB_ROWS][IMAGE_WIDTH];
    col_t                  in_col;
    row_t                  in_row;
    logic [SLOT_WIDTH-1:0] wr_slot;
    logic                  row_done;

    win_state_t            state;
    row_t                  emit_row;
    col_t                  emit_col;
    logic                  flush_pending;
    kernel_t               win_taps;

    logic [SLOT_WIDTH-1:0] ctr_slot;
    logic [SLOT_WIDTH-1:0] up_slot;
    logic [SLOT_WIDTH-1:0] dn_slot;

    //////////////////////////////////////////////////
    // input side
    //////////////////////////////////////////////////

    assign wr_slot  = in_row[SLOT_WIDTH-1:0];
    assign row_done = pixel_valid && (in_col == col_t'(IMAGE_WIDTH - 1));

    always_ff @(posedge clk) begin
        if (pixel_valid) begin
            line_mem[wr_slot][in_col] <= pixel_in;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            in_col <= '0;
            in_row <= '0;
        end else if (pixel_valid) begin
            if (row_done) begin
                in_col <= '0;
                if (in_row == row_t'(IMAGE_HEIGHT - 1)) begin
                    in_row <= '0;
                end else begin
                    in_row <= in_row + 1'b1;
                end
            end else begin
                in_col <= in_col + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // window walk
    //////////////////////////////////////////////////

    // a finished row r+1 releases window row r
    // the last input row releases rows 6 and 7 back to back
    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= IDLE;
            emit_row      <= '0;
            emit_col      <= '0;
            flush_pending <= 1'b0;
        end else if (row_done && in_row != '0) begin
            state         <= EMIT;
            emit_row      <= in_row - 1'b1;
            emit_col      <= '0;
            flush_pending <= (in_row == row_t'(IMAGE_HEIGHT - 1));
        end else if (state == EMIT) begin
            if (emit_col == col_t'(IMAGE_WIDTH - 1)) begin
                emit_col <= '0;
                if (flush_pending) begin
                    emit_row      <= emit_row + 1'b1;
                    flush_pending <= 1'b0;
                end else begin
                    state <= IDLE;
                end
            end else begin
                emit_col <= emit_col + 1'b1;
            end
        end
    end

    // tap read with zero padding on all four edges
    always_comb begin : tap_select
        logic [SLOT_WIDTH-1:0] rd_slot;
        col_t                  rd_col;
        logic                  pad;
        win_taps = '0;
        for (int kr = 0; kr < KERNEL_SIZE; kr++) begin
            for (int kc = 0; kc < KERNEL_SIZE; kc++) begin
                rd_slot = emit_row[SLOT_WIDTH-1:0] + SLOT_WIDTH'(kr) - SLOT_WIDTH'(PAD_SZ);
                rd_col  = emit_col + col_t'(kc) - col_t'(PAD_SZ);
                pad = (kr < PAD_SZ && emit_row == '0)
                   || (kr > PAD_SZ && emit_row == row_t'(IMAGE_HEIGHT - 1))
                   || (kc < PAD_SZ && emit_col == '0)
                   || (kc > PAD_SZ && emit_col == col_t'(IMAGE_WIDTH - 1));
                if (!pad) begin
                    win_taps.taps[kr*KERNEL_SIZE + kc] = line_mem[rd_slot][rd_col];
                end
            end
        end
    end

    assign window = '{valid: (state == EMIT), taps: win_taps};

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    assign ctr_slot = emit_row[SLOT_WIDTH-1:0];
    assign up_slot  = ctr_slot - 1'b1;
    assign dn_slot  = ctr_slot + 1'b1;

    // incoming pixels must miss every row the walk still reads,
    // which matters most during the final-row flush
    assert property (@(posedge clk) disable iff (rst)
        (state == EMIT && pixel_valid) |->
            (wr_slot != ctr_slot)
            && (emit_row == '0 || wr_slot != up_slot)
            && (emit_row == row_t'(IMAGE_HEIGHT - 1) || wr_slot != dn_slot))
        else $error("window_gen: pixel written into a row still being read");

endmodule

`default_nettype wire

//--- hdl/conv_mac.sv
`timescale 1ns/1ns
`default_nettype none

module conv_mac import cnn_pkg::*; (
    input  wire          clk,
    input  wire          rst,
    input  wire conv_window_t window,
    input  wire kernel_t kernel,
    output stage_t       result
);

    prod_t  prod_q [NUM_TAPS];
    logic   prod_valid_q;
    acc_t   sum;
    acc_t   sum_scaled;
    pixel_t sum_sat;
    logic   res_valid_q;
    pixel_t res_data_q;

    //////////////////////////////////////////////////
    // stage one: nine products
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_TAPS; i++) begin
            prod_q[i] <= $signed(window.taps.taps[i]) * $signed(kernel.taps[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prod_valid_q <= 1'b0;
            res_valid_q  <= 1'b0;
        end else begin
            prod_valid_q <= window.valid;
            res_valid_q  <= prod_valid_q;
        end
    end

    //////////////////////////////////////////////////
    // stage two: sum, rescale, saturate
    //////////////////////////////////////////////////

    always_comb begin
        sum = '0;
        for (int i = 0; i < NUM_TAPS; i++) begin
            sum = sum + acc_t'(prod_q[i]);
        end
    end

    // back to Q4.12
    assign sum_scaled = sum >>> FRAC_SZ;
    assign sum_sat    = sat_pixel(sum_scaled);

    always_ff @(posedge clk) begin
        res_data_q <= sum_sat;
    end

    assign result = '{valid: res_valid_q, data: res_data_q};

    // fixed two-cycle latency through the MAC
    assert property (@(posedge clk) disable iff (rst)
        result.valid == $past(window.valid, 2))
        else $error("conv_mac: result valid out of step with window valid");

endmodule

`default_nettype wire

//--- hdl/bn_relu.sv
`timescale 1ns/1ns
`default_nettype none

module bn_relu import cnn_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    input  wire stage_t conv,
    input  wire pixel_t bn_scale,
    input  wire pixel_t bn_bias,
    output stage_t      act
);

    pixel_t in_data;
    prod_t  scaled;
    acc_t   norm;
    pixel_t norm_sat;
    pixel_t relu_data;
    logic   act_valid_q;
    pixel_t act_data_q;

    assign in_data = conv.data;

    // folded batch norm: x * scale + bias
    assign scaled    = in_data * bn_scale;
    assign norm      = (acc_t'(scaled) >>> FRAC_SZ) + acc_t'(bn_bias);
    assign norm_sat  = sat_pixel(norm);
    // relu
    assign relu_data = norm_sat[DATA_WIDTH-1] ? '0 : norm_sat;

    always_ff @(posedge clk) begin
        if (rst) begin
            act_valid_q <= 1'b0;
        end else begin
            act_valid_q <= conv.valid;
        end
    end

    always_ff @(posedge clk) begin
        act_data_q <= relu_data;
    end

    assign act = '{valid: act_valid_q, data: act_data_q};

    assert property (@(posedge clk) disable iff (rst)
        act.valid |-> !act.data[DATA_WIDTH-1])
        else $error("bn_relu: negative value after ReLU");

endmodule

`default_nettype wire

//--- hdl/max_pool.sv
`timescale 1ns/1ns
`default_nettype none

module max_pool import cnn_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    input  wire stage_t act,
    output pixel_t      pool_out,
    output logic        pool_valid
);

    pixel_t                    in_data;
    col_t                      col_cnt;
    row_t                      row_cnt;
    pixel_t                    hold_q;
    pixel_t                    pair_max;
    pixel_t                    part_mem [POOL_COLS];
    logic [POOL_IDX_WIDTH-1:0] part_idx;
    pixel_t                    block_max;
    logic                      emit;
    logic                      pool_valid_q;
    pixel_t                    pool_data_q;

    assign in_data   = act.data;
    assign part_idx  = POOL_IDX_WIDTH'(col_cnt / POOL_SIZE);
    assign pair_max  = (in_data > hold_q) ? in_data : hold_q;
    assign block_max = (part_mem[part_idx] > pair_max) ? part_mem[part_idx] : pair_max;
    // bottom-right corner of each 2x2 block
    assign emit      = act.valid && row_cnt[0] && col_cnt[0];

    //////////////////////////////////////////////////
    // position of the incoming conv result
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (act.valid) begin
            if (col_cnt == col_t'(IMAGE_WIDTH - 1)) begin
                col_cnt <= '0;
                if (row_cnt == row_t'(IMAGE_HEIGHT - 1)) begin
                    row_cnt <= '0;
                end else begin
                    row_cnt <= row_cnt + 1'b1;
                end
            end else begin
                col_cnt <= col_cnt + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // pair and block maxima
    //////////////////////////////////////////////////

    // even column: hold it for the pair
    // odd column on even row: park the pair max for the next row
    always_ff @(posedge clk) begin
        if (act.valid) begin
            if (!col_cnt[0]) begin
                hold_q <= in_data;
            end else if (!row_cnt[0]) begin
                part_mem[part_idx] <= pair_max;
            end
        end
        if (emit) begin
            pool_data_q <= block_max;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pool_valid_q <= 1'b0;
        end else begin
            pool_valid_q <= emit;
        end
    end

    assign pool_out   = pool_data_q;
    assign pool_valid = pool_valid_q;

    assert property (@(posedge clk) disable iff (rst)
        pool_valid |-> $past(act.valid && row_cnt[0] && col_cnt[0]))
        else $error("max_pool: output outside an odd row and column");

endmodule

`default_nettype wire

//--- hdl/conv_pool_top.sv
`timescale 1ns/1ns
`default_nettype none

module conv_pool_top import cnn_pkg::*; (
    input  wire          clk,
    input  wire          rst,
    input  wire pixel_t  pixel_in,
    input  wire          pixel_valid,
    input  wire kernel_t kernel,
    input  wire pixel_t  bn_scale,
    input  wire pixel_t  bn_bias,
    output pixel_t       pool_out,
    output logic         pool_valid
);

    conv_window_t window;
    stage_t       conv_res;
    stage_t       act;

    //////////////////////////////////////////////////
    // window, conv, norm, pool
    //////////////////////////////////////////////////

    window_gen i_window_gen (
        .clk         (clk),
        .rst         (rst),
        .pixel_in    (pixel_in),
        .pixel_valid (pixel_valid),
        .window      (window)
    );

    conv_mac i_conv_mac (
        .clk    (clk),
        .rst    (rst),
        .window (window),
        .kernel (kernel),
        .result (conv_res)
    );

    bn_relu i_bn_relu (
        .clk      (clk),
        .rst      (rst),
        .conv     (conv_res),
        .bn_scale (bn_scale),
        .bn_bias  (bn_bias),
        .act      (act)
    );

    max_pool i_max_pool (
        .clk        (clk),
        .rst        (rst),
        .act        (act),
        .pool_out   (pool_out),
        .pool_valid (pool_valid)
    );

endmodule

`default_nettype wire

//--- tb/conv_pool_model.svh
`ifndef CONV_POOL_MODEL_SVH
`define CONV_POOL_MODEL_SVH

typedef pixel_t frame_t [IMAGE_HEIGHT][IMAGE_WIDTH];

//////////////////////////////////////////////////
// reference arithmetic
//////////////////////////////////////////////////

// clamp into the signed 16-bit range
function automatic pixel_t clamp_word(input longint value);
    if (value > 32767) begin
        return 16'sh7fff;
    end
    if (value < -32768) begin
        return 16'sh8000;
    end
    return pixel_t'(value);
endfunction

// zero outside the tile
function automatic longint padded_pixel(input frame_t img, input int r, input int c);
    if (r < 0 || r >= IMAGE_HEIGHT || c < 0 || c >= IMAGE_WIDTH) begin
        return 0;
    end
    return longint'(img[r][c]);
endfunction

function automatic pixel_t conv_at(input frame_t img, input kernel_t k, input int r, input int c);
    longint sum;
    sum = 0;
    for (int kr = 0; kr < KERNEL_SIZE; kr++) begin
        for (int kc = 0; kc < KERNEL_SIZE; kc++) begin
            sum = sum + padded_pixel(img, r + kr - 1, c + kc - 1)
                      * longint'($signed(k.taps[kr*KERNEL_SIZE + kc]));
        end
    end
    return clamp_word(sum >>> FRAC_SZ);
endfunction

// folded batch norm, then relu
function automatic pixel_t norm_relu(input pixel_t x, input pixel_t scale, input pixel_t bias);
    longint prod;
    pixel_t y;
    prod = (longint'(x) * longint'(scale)) >>> FRAC_SZ;
    y    = clamp_word(prod + longint'(bias));
    return (y < 0) ? pixel_t'(0) : y;
endfunction

function automatic void activation_map(input frame_t img, input kernel_t k,
                                       input pixel_t scale, input pixel_t bias,
                                       output frame_t act);
    for (int r = 0; r < IMAGE_HEIGHT; r++) begin
        for (int c = 0; c < IMAGE_WIDTH; c++) begin
            act[r][c] = norm_relu(conv_at(img, k, r, c), scale, bias);
        end
    end
endfunction

function automatic pixel_t block_max(input frame_t act, input int pr, input int pc);
    pixel_t best;
    best = act[2*pr][2*pc];
    for (int dr = 0; dr < POOL_SIZE; dr++) begin
        for (int dc = 0; dc < POOL_SIZE; dc++) begin
            if (act[2*pr + dr][2*pc + dc] > best) begin
                best = act[2*pr + dr][2*pc + dc];
            end
        end
    end
    return best;
endfunction

`endif

//--- tb/conv_pool_tb.sv
`timescale 1ns/1ns
`default_nettype none

module conv_pool_tb import cnn_pkg::*; ();

    localparam int NUM_FRAMES     = 5;
    localparam int MAX_GAP        = 3;
    localparam int FRAME_GAP      = 2 * IMAGE_WIDTH + 4;
    localparam int FRAME_CYCLES   = IMAGE_WIDTH * IMAGE_HEIGHT * (1 + MAX_GAP) + FRAME_GAP;
    localparam int TIMEOUT_CYCLES = 2 * NUM_FRAMES * FRAME_CYCLES;
    localparam int POOL_OUTPUTS   = POOL_COLS * (IMAGE_HEIGHT / POOL_SIZE);

    logic    clk;
    logic    rst;
    pixel_t  pixel_in;
    logic    pixel_valid;
    kernel_t kernel;
    pixel_t  bn_scale;
    pixel_t  bn_bias;
    pixel_t  pool_out;
    logic    pool_valid;

    integer  seed;
    int      errors = 0;
    int      outputs_seen = 0;
    int      pix_total = 0;
    int      cycle_count = 0;
    pixel_t  exp_q [$];

    `include "conv_pool_model.svh"

    frame_t  image;

    conv_pool_top i_dut (
        .clk         (clk),
        .rst         (rst),
        .pixel_in    (pixel_in),
        .pixel_valid (pixel_valid),
        .kernel      (kernel),
        .bn_scale    (bn_scale),
        .bn_bias     (bn_bias),
        .pool_out    (pool_out),
        .pool_valid  (pool_valid)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // output checks
    //////////////////////////////////////////////////

    // head is checked at negedge, retired at the next posedge
    always @(posedge clk) begin
        if (!rst && pool_valid) begin
            outputs_seen = outputs_seen + 1;
            if (exp_q.size() != 0) begin
                void'(exp_q.pop_front());
            end
        end
    end

    assert property (@(negedge clk) disable iff (rst)
        (pool_valid && exp_q.size() != 0) |-> pool_out == exp_q[0])
        else begin
            errors++;
            $display("mismatch at %0t: pool_out = %0d, expected %0d", $time, pool_out, exp_q[0]);
        end

    assert property (@(negedge clk) disable iff (rst)
        pool_valid |-> exp_q.size() != 0)
        else begin
            errors++;
            $display("output at %0t arrived with no expected value queued", $time);
        end

    // nothing can come out before the third input row is in
    assert property (@(negedge clk) disable iff (rst)
        pool_valid |-> pix_total >= 3 * IMAGE_WIDTH)
        else begin
            errors++;
            $display("output at %0t came before enough input rows arrived", $time);
        end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    function automatic pixel_t random_word(input int shift);
        pixel_t value;
        value = pixel_t'($random(seed));
        return value >>> shift;
    endfunction

    task automatic fill_image(input bit positive, input int shift);
        for (int r = 0; r < IMAGE_HEIGHT; r++) begin
            for (int c = 0; c < IMAGE_WIDTH; c++) begin
                image[r][c] = random_word(shift);
                if (positive) begin
                    image[r][c][DATA_WIDTH-1] = 1'b0;
                end
            end
        end
    endtask

    task automatic random_params(input int shift);
        for (int i = 0; i < NUM_TAPS; i++) begin
            kernel.taps[i] = random_word(shift);
        end
        bn_scale = random_word(shift);
        bn_bias  = random_word(shift);
    endtask

    task automatic send_pixel(input pixel_t value);
        @(posedge clk);
        #1;
        pixel_in    = value;
        pixel_valid = 1'b1;
        pix_total   = pix_total + 1;
    endtask

    task automatic idle_cycles(input int count);
        for (int i = 0; i < count; i++) begin
            @(posedge clk);
            #1;
            pixel_valid = 1'b0;
        end
    endtask

    task automatic queue_expected();
        frame_t act;
        activation_map(image, kernel, bn_scale, bn_bias, act);
        for (int pr = 0; pr < IMAGE_HEIGHT / POOL_SIZE; pr++) begin
            for (int pc = 0; pc < POOL_COLS; pc++) begin
                exp_q.push_back(block_max(act, pr, pc));
            end
        end
    endtask

    task automatic run_frame(input bit with_gaps);
        int gap;
        queue_expected();
        for (int r = 0; r < IMAGE_HEIGHT; r++) begin
            for (int c = 0; c < IMAGE_WIDTH; c++) begin
                send_pixel(image[r][c]);
                gap = with_gaps ? int'($unsigned($random(seed)) % (MAX_GAP + 1)) : 0;
                idle_cycles(gap);
            end
        end
        idle_cycles(FRAME_GAP);
    endtask

    initial begin
        seed        = 32'h83e71b66;
        rst         = 1'b1;
        pixel_in    = '0;
        pixel_valid = 1'b0;
        kernel      = '0;
        bn_scale    = '0;
        bn_bias     = '0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        // identity kernel, so each output is the max of its input block
        kernel.taps[NUM_TAPS / 2] = Q_ONE;
        bn_scale = Q_ONE;
        bn_bias  = '0;
        fill_image(1'b1, 1);
        run_frame(1'b0);

        // full-range values, lots of saturation and relu zeros
        random_params(0);
        fill_image(1'b0, 0);
        run_frame(1'b0);

        // all-ones kernel on 0.5, negated and biased by 5.0 to expose the padding
        for (int i = 0; i < NUM_TAPS; i++) begin
            kernel.taps[i] = Q_ONE;
        end
        bn_scale = -Q_ONE;
        bn_bias  = 16'sh5000;
        for (int r = 0; r < IMAGE_HEIGHT; r++) begin
            for (int c = 0; c < IMAGE_WIDTH; c++) begin
                image[r][c] = 16'sh0800;
            end
        end
        run_frame(1'b0);

        // two frames with ragged rows
        for (int f = 0; f < 2; f++) begin
            random_params(3);
            fill_image(1'b0, 2);
            run_frame(1'b1);
        end
        idle_cycles(8);

        assert (exp_q.size() == 0)
            else begin
                errors++;
                $display("%0d expected outputs never arrived", exp_q.size());
            end
        assert (outputs_seen == NUM_FRAMES * POOL_OUTPUTS)
            else begin
                errors++;
                $display("mismatch at %0t: output count = %0d, expected %0d",
                         $time, outputs_seen, NUM_FRAMES * POOL_OUTPUTS);
            end

        $display("errors: %0d, outputs: %0d of %0d",
                 errors, outputs_seen, NUM_FRAMES * POOL_OUTPUTS);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+tb
common/cnn_pkg.sv
window_gen/window_gen.sv
hdl/conv_mac.sv
hdl/bn_relu.sv
hdl/max_pool.sv
hdl/conv_pool_top.sv
tb/conv_pool_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= conv_pool_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard tb/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
